// File: tb.f
verilog/fp_pkg.sv
verilog/fp_classify.sv
verilog/fp_compare.sv
verilog/fp_result_merge.sv
verilog/fp_wb_regs.sv
verilog/fp_misc_top.sv
tb/fp_misc_tb.sv

// File: tb/fp_misc_tb.sv
// fp misc unit testbench
// table of fclass, compare and min/max cases pushed over wishbone
// with result, flags and operand readback checked per row
module fp_misc_tb;

  localparam int FLEN        = 64;
  localparam int ACK_TIMEOUT = 16;  // cycles to wait for ack

  typedef struct packed {
    fp_pkg::fp_op_e op;
    logic           fmt;   // 0 single, 1 double
    logic [63:0]    a;
    logic [63:0]    b;
    logic [63:0]    res;   // expected result
    logic           nv;    // expected invalid flag
  } vec_t;

  logic             clk;
  logic             rst;
  logic             cyc;
  logic             stb;
  logic             we;
  fp_pkg::wb_adr_t  adr;
  fp_pkg::wb_data_t dat_w;
  logic             ack;
  fp_pkg::wb_data_t dat_r;

  vec_t rows[$];

  fp_misc_top #(.FLEN(FLEN)) dut_i (
    .clk  (clk),
    .rst  (rst),
    .cyc  (cyc),
    .stb  (stb),
    .we   (we),
    .adr  (adr),
    .dat_w(dat_w),
    .ack  (ack),
    .dat_r(dat_r)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // called on a falling edge with the request already driven
  task automatic wait_ack(input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (!ack && n < ACK_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!ack) begin
      abort_run($sformatf("bus %s got no ack within %0d cycles", what, ACK_TIMEOUT));
    end
  endtask

  task automatic bus_write(input fp_pkg::wb_adr_t a, input fp_pkg::wb_data_t d);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = 1'b1;
    adr   = a;
    dat_w = d;
    wait_ack($sformatf("write to %0d", a));
    cyc = 1'b0;  // release on the ack cycle
    stb = 1'b0;
    we  = 1'b0;
    @(negedge clk);
    check_val("ack pulse width", ack, 1'b0);  // exactly one ack
  endtask

  task automatic bus_read(input fp_pkg::wb_adr_t a, output fp_pkg::wb_data_t d);
    cyc = 1'b1;
    stb = 1'b1;
    we  = 1'b0;
    adr = a;
    wait_ack($sformatf("read from %0d", a));
    d   = dat_r;  // valid while ack high
    cyc = 1'b0;
    stb = 1'b0;
    @(negedge clk);
    check_val("ack pulse width", ack, 1'b0);
  endtask

  task automatic idle_gap();
    repeat ($urandom % 4) @(negedge clk);  // 0 to 3 idle cycles
  endtask

  // single operand in the low word with junk above it
  function automatic logic [63:0] pad_single(input logic [31:0] v);
    return {~v ^ 32'h3c5a_96e1, v};
  endfunction

  function automatic logic [63:0] nan_box(input logic [31:0] v);
    return {32'hffff_ffff, v};
  endfunction

  task automatic add_row(input fp_pkg::fp_op_e op, input logic fmt, input logic [63:0] a,
                         input logic [63:0] b, input logic [63:0] res, input logic nv);
    vec_t v;
    v.op  = op;
    v.fmt = fmt;
    v.a   = a;
    v.b   = b;
    v.res = res;
    v.nv  = nv;
    rows.push_back(v);
  endtask

  task automatic build_table();
    // fclass double with one row per class
    add_row(fp_pkg::OP_FCLASS, 1, 64'hfff0000000000000, 64'h0, 64'h001, 0);  // -inf
    add_row(fp_pkg::OP_FCLASS, 1, 64'hbff0000000000000, 64'h0, 64'h002, 0);  // -1.0
    add_row(fp_pkg::OP_FCLASS, 1, 64'h8000000000000001, 64'h0, 64'h004, 0);
    add_row(fp_pkg::OP_FCLASS, 1, 64'h8000000000000000, 64'h0, 64'h008, 0);  // -0
    add_row(fp_pkg::OP_FCLASS, 1, 64'h0000000000000000, 64'h0, 64'h010, 0);
    add_row(fp_pkg::OP_FCLASS, 1, 64'h000fffffffffffff, 64'h0, 64'h020, 0);  // max subnormal
    add_row(fp_pkg::OP_FCLASS, 1, 64'h3ff0000000000000, 64'h0, 64'h040, 0);
    add_row(fp_pkg::OP_FCLASS, 1, 64'h7ff0000000000000, 64'h0, 64'h080, 0);
    add_row(fp_pkg::OP_FCLASS, 1, 64'hfff0000000000001, 64'h0, 64'h100, 0);  // snan with sign set
    add_row(fp_pkg::OP_FCLASS, 1, 64'h7ff8000000000000, 64'h0, 64'h200, 0);
    // fclass single over a junk upper word
    add_row(fp_pkg::OP_FCLASS, 0, pad_single(32'hff800000), 64'h0, 64'h001, 0);
    add_row(fp_pkg::OP_FCLASS, 0, pad_single(32'hbf800000), 64'h0, 64'h002, 0);
    add_row(fp_pkg::OP_FCLASS, 0, pad_single(32'h80000001), 64'h0, 64'h004, 0);
    add_row(fp_pkg::OP_FCLASS, 0, pad_single(32'h80000000), 64'h0, 64'h008, 0);
    add_row(fp_pkg::OP_FCLASS, 0, pad_single(32'h00000000), 64'h0, 64'h010, 0);
    add_row(fp_pkg::OP_FCLASS, 0, pad_single(32'h007fffff), 64'h0, 64'h020, 0);
    add_row(fp_pkg::OP_FCLASS, 0, pad_single(32'h3f800000), 64'h0, 64'h040, 0);
    add_row(fp_pkg::OP_FCLASS, 0, pad_single(32'h7f800000), 64'h0, 64'h080, 0);
    add_row(fp_pkg::OP_FCLASS, 0, pad_single(32'hff800001), 64'h0, 64'h100, 0);
    add_row(fp_pkg::OP_FCLASS, 0, pad_single(32'h7fc00000), 64'h0, 64'h200, 0);
    // double compares
    add_row(fp_pkg::OP_FEQ, 1, 64'h3ff0000000000000, 64'h3ff0000000000000, 64'h1, 0);
    add_row(fp_pkg::OP_FEQ, 1, 64'h0000000000000000, 64'h8000000000000000, 64'h1, 0);
    add_row(fp_pkg::OP_FEQ, 1, 64'h7ff8000000000000, 64'h3ff0000000000000, 64'h0, 0);
    add_row(fp_pkg::OP_FEQ, 1, 64'h7ff0000000000001, 64'h3ff0000000000000, 64'h0, 1);
    add_row(fp_pkg::OP_FLT, 1, 64'hbff0000000000000, 64'h3ff0000000000000, 64'h1, 0);
    add_row(fp_pkg::OP_FLT, 1, 64'h3ff0000000000000, 64'hbff0000000000000, 64'h0, 0);
    add_row(fp_pkg::OP_FLT, 1, 64'h8000000000000000, 64'h0000000000000000, 64'h0, 0);
    add_row(fp_pkg::OP_FLT, 1, 64'h7ff8000000000000, 64'h3ff0000000000000, 64'h0, 1);
    add_row(fp_pkg::OP_FLE, 1, 64'h0000000000000000, 64'h8000000000000000, 64'h1, 0);
    add_row(fp_pkg::OP_FLE, 1, 64'hc000000000000000, 64'hbff0000000000000, 64'h1, 0);
    add_row(fp_pkg::OP_FLE, 1, 64'h3ff0000000000000, 64'h7ff8000000000000, 64'h0, 1);
    // single compares where the first row differs only above bit 31
    add_row(fp_pkg::OP_FEQ, 0, 64'h12345678_3f800000, 64'hcafef00d_3f800000, 64'h1, 0);
    add_row(fp_pkg::OP_FLT, 0, pad_single(32'hff800000), pad_single(32'h3f800000), 64'h1, 0);
    add_row(fp_pkg::OP_FLE, 0, pad_single(32'h7f800001), pad_single(32'h00000000), 64'h0, 1);
    add_row(fp_pkg::OP_FEQ, 0, pad_single(32'h7fc00000), pad_single(32'h7fc00000), 64'h0, 0);
    add_row(fp_pkg::OP_FLT, 0, pad_single(32'h00000001), pad_single(32'h00000002), 64'h1, 0);
    // double min/max
    add_row(fp_pkg::OP_FMIN, 1, 64'h0000000000000000, 64'h8000000000000000,
            64'h8000000000000000, 0);  // -0 below +0
    add_row(fp_pkg::OP_FMAX, 1, 64'h8000000000000000, 64'h0000000000000000,
            64'h0000000000000000, 0);
    add_row(fp_pkg::OP_FMIN, 1, 64'h3ff0000000000000, 64'hc000000000000000,
            64'hc000000000000000, 0);
    add_row(fp_pkg::OP_FMAX, 1, 64'h3ff0000000000000, 64'hc000000000000000,
            64'h3ff0000000000000, 0);
    add_row(fp_pkg::OP_FMIN, 1, 64'h4000000000000000, 64'h3ff0000000000000,
            64'h3ff0000000000000, 0);  // both positive
    add_row(fp_pkg::OP_FMIN, 1, 64'hbff0000000000000, 64'hc000000000000000,
            64'hc000000000000000, 0);  // both negative
    add_row(fp_pkg::OP_FMAX, 1, 64'hc000000000000000, 64'hbff0000000000000,
            64'hbff0000000000000, 0);
    add_row(fp_pkg::OP_FMIN, 1, 64'h7ff8000000000000, 64'h3ff0000000000000,
            64'h3ff0000000000000, 0);  // one quiet nan
    add_row(fp_pkg::OP_FMAX, 1, 64'h3ff0000000000000, 64'h7ff0000000000001,
            64'h3ff0000000000000, 1);  // one signaling nan
    add_row(fp_pkg::OP_FMIN, 1, 64'h7ff8000000000000, 64'h7ff0000000000001,
            64'h7ff8000000000000, 1);
    add_row(fp_pkg::OP_FMAX, 1, 64'h7fff000000000000, 64'hfff8000000000000,
            64'h7ff8000000000000, 0);  // both quiet so the payload is dropped
    // single min/max with boxed results
    add_row(fp_pkg::OP_FMIN, 0, pad_single(32'h3f800000), pad_single(32'hbf800000),
            nan_box(32'hbf800000), 0);
    add_row(fp_pkg::OP_FMAX, 0, pad_single(32'h00000000), pad_single(32'h80000000),
            nan_box(32'h00000000), 0);
    add_row(fp_pkg::OP_FMAX, 0, pad_single(32'h3f800000), pad_single(32'h40000000),
            nan_box(32'h40000000), 0);
    add_row(fp_pkg::OP_FMIN, 0, pad_single(32'h7fc00000), pad_single(32'h40000000),
            nan_box(32'h40000000), 0);
    add_row(fp_pkg::OP_FMAX, 0, pad_single(32'h7f800001), pad_single(32'hff800000),
            nan_box(32'hff800000), 1);
    add_row(fp_pkg::OP_FMIN, 0, pad_single(32'h7fc00001), pad_single(32'h7f800001),
            nan_box(32'h7fc00000), 1);  // both nan gives canonical
  endtask

  initial begin
    vec_t             v;
    fp_pkg::wb_data_t rd;
    logic [63:0]      res;
    rst   = 1'b1;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    dat_w = '0;
    void'($urandom(53170));
    build_table();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // result side comes out of reset cleared
    bus_read(fp_pkg::RES_LO, rd);
    check_val("res_lo after reset", rd, 64'h0);
    bus_read(fp_pkg::RES_HI, rd);
    check_val("res_hi after reset", rd, 64'h0);
    bus_read(fp_pkg::FLAGS, rd);
    check_val("flags after reset", rd, 64'h0);

    for (int i = 0; i < rows.size(); i++) begin
      v = rows[i];
      bus_write(fp_pkg::A_LO, v.a[31:0]);
      idle_gap();
      bus_write(fp_pkg::A_HI, v.a[63:32]);
      idle_gap();
      bus_write(fp_pkg::B_LO, v.b[31:0]);
      idle_gap();
      bus_write(fp_pkg::B_HI, v.b[63:32]);
      idle_gap();
      bus_write(fp_pkg::CTRL, {28'd0, v.op, v.fmt});
      bus_read(fp_pkg::RES_LO, rd);  // straight after ctrl with no gap
      res[31:0] = rd;
      bus_read(fp_pkg::RES_HI, rd);
      res[63:32] = rd;
      check_val($sformatf("row %0d result", i), res, v.res);
      bus_read(fp_pkg::FLAGS, rd);
      check_val($sformatf("row %0d nv", i), rd, {63'd0, v.nv});
      idle_gap();
      // operand and ctrl readback
      bus_read(fp_pkg::A_LO, rd);
      check_val($sformatf("row %0d a_lo", i), rd, v.a[31:0]);
      bus_read(fp_pkg::A_HI, rd);
      check_val($sformatf("row %0d a_hi", i), rd, v.a[63:32]);
      bus_read(fp_pkg::B_LO, rd);
      check_val($sformatf("row %0d b_lo", i), rd, v.b[31:0]);
      bus_read(fp_pkg::B_HI, rd);
      check_val($sformatf("row %0d b_hi", i), rd, v.b[63:32]);
      bus_read(fp_pkg::CTRL, rd);
      check_val($sformatf("row %0d ctrl", i), rd, {60'd0, v.op, v.fmt});
      idle_gap();
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: verilog/fp_misc_top.sv
// fp misc unit top level
// wishbone register block feeding classifier, comparator and merge stage
module fp_misc_top #(
  parameter int FLEN = 64  // 32 or 64
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             cyc,
  input  logic             stb,
  input  logic             we,
  input  fp_pkg::wb_adr_t  adr,
  input  fp_pkg::wb_data_t dat_w,
  output logic             ack,
  output fp_pkg::wb_data_t dat_r
);

  logic [FLEN-1:0]     operand_a;
  logic [FLEN-1:0]     operand_b;
  logic [FLEN-1:0]     result;
  fp_pkg::fp_ctrl_t    ctrl;
  fp_pkg::class_mask_t class_a;
  fp_pkg::cmp_res_t    cmp;
  logic                go;
  logic                nv;
  logic                max_sel;

  assign max_sel = (ctrl.op == fp_pkg::OP_FMAX);  // else min direction

  fp_wb_regs #(.FLEN(FLEN)) regs_i (
    .clk      (clk),
    .rst      (rst),
    .cyc      (cyc),
    .stb      (stb),
    .we       (we),
    .adr      (adr),
    .dat_w    (dat_w),
    .ack      (ack),
    .dat_r    (dat_r),
    .result   (result),
    .nv       (nv),
    .operand_a(operand_a),
    .operand_b(operand_b),
    .ctrl     (ctrl),
    .go       (go)
  );

  // fclass only looks at operand a
  fp_classify #(.FLEN(FLEN)) classify_i (
    .operand(operand_a),
    .fmt    (ctrl.fmt),
    .mask   (class_a)
  );

  fp_compare #(.FLEN(FLEN)) compare_i (
    .operand_a(operand_a),
    .operand_b(operand_b),
    .fmt      (ctrl.fmt),
    .max_sel  (max_sel),
    .cmp      (cmp)
  );

  fp_result_merge #(.FLEN(FLEN)) merge_i (
    .clk      (clk),
    .rst      (rst),
    .go       (go),
    .ctrl     (ctrl),
    .operand_a(operand_a),
    .operand_b(operand_b),
    .class_a  (class_a),
    .cmp      (cmp),
    .result   (result),
    .nv       (nv)
  );

endmodule

// File: verilog/fp_wb_regs.sv
// wishbone classic slave for the fp misc unit
// operand and control registers, go pulse, result readback
module fp_wb_regs #(
  parameter int FLEN = 64
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             cyc,
  input  logic             stb,
  input  logic             we,
  input  fp_pkg::wb_adr_t  adr,
  input  fp_pkg::wb_data_t dat_w,
  output logic             ack,
  output fp_pkg::wb_data_t dat_r,
  input  logic [FLEN-1:0]  result,
  input  logic             nv,
  output logic [FLEN-1:0]  operand_a,
  output logic [FLEN-1:0]  operand_b,
  output fp_pkg::fp_ctrl_t ctrl,
  output logic             go
);

  localparam bit HAS_HI = (FLEN == 64);  // upper words exist

  fp_pkg::wb_data_t a_lo;
  fp_pkg::wb_data_t a_hi;
  fp_pkg::wb_data_t b_lo;
  fp_pkg::wb_data_t b_hi;
  fp_pkg::wb_data_t rd_mux;
  logic [63:0]      res64;
  logic             accept;  // new transaction this edge
  logic             wr;

  assign accept = cyc && stb && !ack;
  assign wr     = accept && we;
  assign res64  = 64'(result);  // high word reads zero for flen 32

  assign operand_a = FLEN'({a_hi, a_lo});
  assign operand_b = FLEN'({b_hi, b_lo});

  always_comb begin
    case (adr)
      fp_pkg::A_LO:   rd_mux = a_lo;
      fp_pkg::A_HI:   rd_mux = a_hi;
      fp_pkg::B_LO:   rd_mux = b_lo;
      fp_pkg::B_HI:   rd_mux = b_hi;
      fp_pkg::CTRL:   rd_mux = 32'(ctrl);
      fp_pkg::RES_LO: rd_mux = res64[31:0];
      fp_pkg::RES_HI: rd_mux = res64[63:32];
      default:        rd_mux = {31'd0, nv};  // flags, nv only
    endcase
  end

  // register writes, res and flags are read only
  always_ff @(posedge clk) begin
    if (rst) begin
      a_lo <= '0;
      a_hi <= '0;
      b_lo <= '0;
      b_hi <= '0;
      ctrl <= '0;
    end else if (wr) begin
      case (adr)
        fp_pkg::A_LO: a_lo <= dat_w;
        fp_pkg::A_HI: if (HAS_HI) a_hi <= dat_w;
        fp_pkg::B_LO: b_lo <= dat_w;
        fp_pkg::B_HI: if (HAS_HI) b_hi <= dat_w;
        fp_pkg::CTRL: ctrl <= fp_pkg::fp_ctrl_t'(dat_w[3:0]);
        default: ;
      endcase
    end
  end

  // bus handshake, one ack per accepted cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      ack   <= 1'b0;
      go    <= 1'b0;
      dat_r <= '0;
    end else begin
      ack <= accept;
      go  <= wr && (adr == fp_pkg::CTRL);  // merge loads one edge later
      if (accept) begin
        dat_r <= rd_mux;  // held until the next access
      end
    end
  end

  a_ack_follows_req: assert property (@(posedge clk) disable iff (rst)
    ack |-> $past(cyc && stb))
    else $error("ack without a request");

  a_ack_single: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
    else $error("ack held for two cycles");

endmodule

// File: verilog/fp_result_merge.sv
// fp result merge stage
// picks the result per op, applies nan rules and nan-boxing,
// registers result and nv on go
module fp_result_merge #(
  parameter int FLEN = 64
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                go,
  input  fp_pkg::fp_ctrl_t    ctrl,
  input  logic [FLEN-1:0]     operand_a,
  input  logic [FLEN-1:0]     operand_b,
  input  fp_pkg::class_mask_t class_a,
  input  fp_pkg::cmp_res_t    cmp,
  output logic [FLEN-1:0]     result,
  output logic                nv
);

  logic            dbl;
  logic [63:0]     pick64;    // chosen operand, widened
  logic [63:0]     minmax64;  // boxed min/max value
  logic [FLEN-1:0] result_d;
  logic            nv_d;

  assign dbl    = (FLEN == 64) && ctrl.fmt;
  assign pick64 = 64'(cmp.pick_b ? operand_b : operand_a);

  // single results get ones above bit 31, dropped again when flen is 32
  always_comb begin
    if (cmp.a_nan && cmp.b_nan) begin
      minmax64 = dbl ? fp_pkg::CANON_NAN_D : {32'hffff_ffff, fp_pkg::CANON_NAN_S};
    end else begin
      minmax64 = dbl ? pick64 : {32'hffff_ffff, pick64[31:0]};
    end
  end

  always_comb begin
    result_d = '0;
    nv_d     = 1'b0;
    case (ctrl.op)
      fp_pkg::OP_FCLASS: result_d = FLEN'(class_a);  // zero-extended mask
      fp_pkg::OP_FEQ: begin
        result_d[0] = cmp.eq;
        nv_d        = cmp.any_snan;  // quiet compare
      end
      fp_pkg::OP_FLT: begin
        result_d[0] = cmp.lt;
        nv_d        = cmp.unordered;  // signaling compare
      end
      fp_pkg::OP_FLE: begin
        result_d[0] = cmp.lt || cmp.eq;
        nv_d        = cmp.unordered;
      end
      fp_pkg::OP_FMIN, fp_pkg::OP_FMAX: begin
        result_d = minmax64[FLEN-1:0];
        nv_d     = cmp.any_snan;
      end
      default: ;  // unused op codes give zero
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result <= '0;
      nv     <= 1'b0;
    end else if (go) begin
      result <= result_d;
      nv     <= nv_d;
    end
  end

  // classifier output must be one-hot whenever it gets used
  a_class_onehot: assert property (@(posedge clk) disable iff (rst)
    go |-> $onehot(class_a))
    else $error("fclass mask not one-hot");

  // ctrl writes are at least two cycles apart
  a_go_pulse: assert property (@(posedge clk) disable iff (rst) go |=> !go)
    else $error("go high two cycles in a row");

endmodule

// File: verilog/fp_compare.sv
// fp comparator
// ieee eq/lt with unordered and snan detect, plus the fmin/fmax pick
// purely combinational
module fp_compare #(
  parameter int FLEN = 64
) (
  input  logic [FLEN-1:0]  operand_a,
  input  logic [FLEN-1:0]  operand_b,
  input  logic             fmt,      // 0 single, 1 double
  input  logic             max_sel,  // high for fmax
  output fp_pkg::cmp_res_t cmp
);

  // decoded operand, mag is exponent over mantissa
  typedef struct packed {
    logic        sign;
    logic [62:0] mag;
    logic        nan;
    logic        snan;
  } fp_fields_t;

  function automatic fp_fields_t decode(input logic [63:0] v, input logic dbl);
    fp_fields_t  f;
    logic [10:0] e;
    logic [51:0] m;
    logic        q;
    e      = dbl ? v[62:52] : {3'b000, v[30:23]};
    m      = dbl ? v[51:0] : {29'd0, v[22:0]};
    q      = dbl ? v[51] : v[22];  // quiet bit
    f.sign = dbl ? v[63] : v[31];
    f.mag  = {e, m};  // single fields zero-extended, order kept
    f.nan  = (e == (dbl ? 11'h7ff : 11'h0ff)) && (m != '0);
    f.snan = f.nan && !q;
    return f;
  endfunction

  fp_fields_t fa;
  fp_fields_t fb;
  logic       dbl;
  logic       unord;
  logic       both_zero;  // +0/-0 in any mix
  logic       same;       // bit-identical in the chosen format
  logic       a_below;    // a < b, -0 below +0
  logic       b_below;

  assign dbl = (FLEN == 64) && fmt;
  assign fa  = decode(64'(operand_a), dbl);
  assign fb  = decode(64'(operand_b), dbl);

  assign unord     = fa.nan || fb.nan;
  assign both_zero = (fa.mag == '0) && (fb.mag == '0);
  assign same      = (fa.sign == fb.sign) && (fa.mag == fb.mag);

  // sign-magnitude order, negatives compare reversed
  assign a_below = (fa.sign != fb.sign) ? fa.sign :
                   (fa.sign ? (fa.mag > fb.mag) : (fa.mag < fb.mag));
  assign b_below = (fa.sign != fb.sign) ? fb.sign :
                   (fb.sign ? (fb.mag > fa.mag) : (fb.mag < fa.mag));

  always_comb begin
    cmp.eq        = !unord && (same || both_zero);  // +0 == -0
    cmp.lt        = !unord && !both_zero && a_below;
    cmp.unordered = unord;
    cmp.any_snan  = fa.snan || fb.snan;
    cmp.a_nan     = fa.nan;
    cmp.b_nan     = fb.nan;
    if (fa.nan != fb.nan) begin
      cmp.pick_b = fa.nan;  // take the non-nan side
    end else begin
      // both nan ends up canonical in the merge stage
      cmp.pick_b = max_sel ? a_below : b_below;
    end
  end

endmodule

// File: verilog/fp_classify.sv
// fp classifier
// ten-class fclass mask for a single or double operand, no clock
module fp_classify #(
  parameter int FLEN = 64  // 32 or 64
) (
  input  logic [FLEN-1:0]     operand,
  input  logic                fmt,   // 0 single, 1 double
  output fp_pkg::class_mask_t mask
);

  logic [63:0] op64;     // operand widened so slicing is FLEN independent
  logic        dbl;
  logic        sign;
  logic [10:0] exp;
  logic [51:0] man;
  logic [10:0] exp_max;
  logic        quiet;    // mantissa msb
  logic        exp_zero;
  logic        exp_ones;
  logic        man_zero;

  assign op64 = 64'(operand);
  assign dbl  = (FLEN == 64) && fmt;  // flen 32 is always single

  // single lives in the low word, upper word ignored
  assign sign = dbl ? op64[63] : op64[31];
  assign exp  = dbl ? op64[62:52] : {3'b000, op64[30:23]};
  assign man  = dbl ? op64[51:0] : {29'd0, op64[22:0]};

  assign exp_max = dbl ? 11'h7ff : 11'h0ff;
  assign quiet   = dbl ? man[51] : man[22];

  assign exp_zero = (exp == '0);
  assign exp_ones = (exp == exp_max);
  assign man_zero = (man == '0);

  always_comb begin
    mask = '0;
    if (exp_ones && !man_zero) begin
      // nan, sign does not matter
      mask[9] = quiet;
      mask[8] = !quiet;
    end else if (exp_ones) begin
      // infinity
      mask[0] = sign;
      mask[7] = !sign;
    end else if (exp_zero && man_zero) begin
      mask[3] = sign;   // -0
      mask[4] = !sign;  // +0
    end else if (exp_zero) begin
      mask[2] = sign;   // -subnormal
      mask[5] = !sign;
    end else begin
      mask[1] = sign;   // normal
      mask[6] = !sign;
    end
  end

endmodule

// File: verilog/fp_pkg.sv
// fp misc unit shared definitions
// op codes, control word, class mask, compare flags, register map
package fp_pkg;

  // operation select, lives in ctrl[3:1]
  typedef enum logic [2:0] {
    OP_FCLASS = 3'd0,
    OP_FEQ    = 3'd1,
    OP_FLT    = 3'd2,
    OP_FLE    = 3'd3,
    OP_FMIN   = 3'd4,
    OP_FMAX   = 3'd5
  } fp_op_e;

  typedef struct packed {
    fp_op_e op;   // bits 3:1
    logic   fmt;  // 0 single, 1 double
  } fp_ctrl_t;

  // one-hot fclass mask
  // 0 -inf, 1 -norm, 2 -subn, 3 -0, 4 +0, 5 +subn, 6 +norm, 7 +inf, 8 snan, 9 qnan
  typedef logic [9:0] class_mask_t;

  typedef struct packed {
    logic eq;
    logic lt;
    logic unordered;  // either operand nan
    logic any_snan;
    logic a_nan;
    logic b_nan;
    logic pick_b;     // b is the min/max choice
  } cmp_res_t;

  typedef logic [31:0] wb_data_t;
  typedef logic [2:0]  wb_adr_t;  // word address

  // register map
  localparam wb_adr_t A_LO   = 3'd0;
  localparam wb_adr_t A_HI   = 3'd1;
  localparam wb_adr_t B_LO   = 3'd2;
  localparam wb_adr_t B_HI   = 3'd3;
  localparam wb_adr_t CTRL   = 3'd4;
  localparam wb_adr_t RES_LO = 3'd5;
  localparam wb_adr_t RES_HI = 3'd6;
  localparam wb_adr_t FLAGS  = 3'd7;

  localparam logic [31:0] CANON_NAN_S = 32'h7fc0_0000;
  localparam logic [63:0] CANON_NAN_D = 64'h7ff8_0000_0000_0000;

endpackage
